/* design/board_io_macros.svh */
// board_io macros
// address map and build-time sizes for the on-board I/O peripheral
// all register offsets are the low address byte inside the I/O page
`ifndef BOARD_IO_MACROS_SVH
`define BOARD_IO_MACROS_SVH

// upper address byte of the peripheral page
`define IO_PAGE             8'h10

`define REG_SW              8'h00   // switches, read only
`define REG_BTN             8'h02   // buttons, read only
`define REG_LED             8'h10   // leds, read/write
`define REG_DIGIT_BASE      8'h20   // four digit registers 0x20..0x23
`define REG_DISP_CTRL       8'h24   // display mode, write only

// scan tick every 2^W clocks, ~1.3 ms per digit at 50 MHz
`define SCAN_DIV_W_DEFAULT  16

`endif

/* design/board_io_pkg.sv */
// board_io_pkg
// shared types for the on-board I/O peripheral: bus bundles for the
// four-phase req/ack handshake, slave states, display glyph codes and
// the digit register bundle handed from the register block to the scanner
package board_io_pkg;

    typedef struct packed {
        logic        req;    // master request, held until ack
        logic        we;     // 1 = write, 0 = read
        logic [15:0] addr;   // byte address, upper byte selects page
        logic [15:0] wdata;  // write data, stable while req high
    } io_bus_req_t;

    typedef struct packed {
        logic        ack;    // slave acknowledge
        logic [15:0] rdata;  // valid while ack high
    } io_bus_rsp_t;

    typedef enum logic [1:0] {
        BUS_IDLE    = 2'd0,  // waiting for req
        BUS_ACK     = 2'd1,  // ack high, waiting for req to drop
        BUS_RELEASE = 2'd2   // ack low again, one cycle before idle
    } bus_state_e;

    typedef enum logic [4:0] {
        GLYPH_0 = 5'h00, GLYPH_1 = 5'h01, GLYPH_2 = 5'h02, GLYPH_3 = 5'h03,
        GLYPH_4 = 5'h04, GLYPH_5 = 5'h05, GLYPH_6 = 5'h06, GLYPH_7 = 5'h07,
        GLYPH_8 = 5'h08, GLYPH_9 = 5'h09, GLYPH_A = 5'h0a, GLYPH_B = 5'h0b,
        GLYPH_C = 5'h0c, GLYPH_D = 5'h0d, GLYPH_E = 5'h0e, GLYPH_F = 5'h0f,
        GLYPH_BLANK = 5'h10,
        GLYPH_DASH  = 5'h11,
        GLYPH_J     = 5'h12
    } glyph_e;

    typedef struct packed {
        logic            raw_mode;  // 1 = segments straight from register
        logic [3:0][7:0] digit;     // digit[0] is the leftmost display
    } digit_regs_t;

endpackage

/* design/input_sync.sv */
// input_sync
// two flop synchronizer for the board switches and buttons
// outputs follow the pins by exactly two clock cycles
`timescale 1ns/1ps

module input_sync (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] sw,        // raw switch pins
    input  logic [4:0]  btn,       // raw button pins
    output logic [15:0] sw_sync,
    output logic [4:0]  btn_sync
);

    logic [15:0] sw_meta;   // first stage, may go metastable
    logic [4:0]  btn_meta;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_meta  <= '0;
            btn_meta <= '0;
            sw_sync  <= '0;
            btn_sync <= '0;
        end else begin
            sw_meta  <= sw;
            btn_meta <= btn;
            sw_sync  <= sw_meta;   // second stage
            btn_sync <= btn_meta;
        end
    end

    // floating button pins must not leak x into the bus read path
    a_btn_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(btn_sync));

endmodule

/* design/io_regs.sv */
// io_regs
// bus slave of the I/O page: four-phase req/ack state machine,
// address decode, led register, digit registers and display mode flag
// the access is done on the edge where req is first seen high
`timescale 1ns/1ps

`include "board_io_macros.svh"

module io_regs import board_io_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  io_bus_req_t bus_req,
    output io_bus_rsp_t bus_rsp,
    input  logic [15:0] sw_sync,
    input  logic [4:0]  btn_sync,
    output logic [15:0] led,
    output digit_regs_t digits
);

    bus_state_e  state;
    logic        access;     // req seen in idle, do the access now
    logic        page_hit;
    logic [7:0]  offset;
    logic        wr_en;
    logic [15:0] rd_mux;
    logic [15:0] rdata_q;
    logic [15:0] led_q;
    digit_regs_t digits_q;

    assign page_hit = (bus_req.addr[15:8] == `IO_PAGE);
    assign offset   = bus_req.addr[7:0];
    assign access   = (state == BUS_IDLE) && bus_req.req;
    assign wr_en    = access && bus_req.we && page_hit;

    // handshake fsm
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (bus_req.req)
                        state <= BUS_ACK;      // ack next cycle
                end
                BUS_ACK: begin
                    if (!bus_req.req)
                        state <= BUS_RELEASE;  // master let go, drop ack
                end
                BUS_RELEASE: state <= BUS_IDLE;
                default:     state <= BUS_IDLE;
            endcase
        end
    end

    // read decode, off-page and unmapped offsets read 0
    always_comb begin
        rd_mux = '0;
        if (page_hit) begin
            case (offset)
                `REG_SW:  rd_mux = sw_sync;
                `REG_BTN: rd_mux = {11'd0, btn_sync};   // zero extend
                `REG_LED: rd_mux = led_q;
                default:  rd_mux = '0;
            endcase
        end
    end

    // read data captured on the access edge, held through ack
    always_ff @(posedge clk) begin
        if (access)
            rdata_q <= rd_mux;
    end

    // write side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_q             <= '0;
            digits_q.raw_mode <= 1'b0;
            for (int i = 0; i < 4; i++)
                digits_q.digit[i] <= {3'b000, GLYPH_BLANK};  // blank, dp off
        end else if (wr_en) begin
            if (offset == `REG_LED)
                led_q <= bus_req.wdata;
            else if (offset[7:2] == `REG_DIGIT_BASE >> 2)
                digits_q.digit[offset[1:0]] <= bus_req.wdata[7:0];
            else if (offset == `REG_DISP_CTRL)
                digits_q.raw_mode <= |bus_req.wdata;   // any nonzero = raw
        end
    end

    assign bus_rsp.ack   = (state == BUS_ACK);
    assign bus_rsp.rdata = rdata_q;
    assign led           = led_q;
    assign digits        = digits_q;

    // slave only answers a request that was actually made
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_rsp.ack) |-> $past(bus_req.req));

    // four-phase order, master drops req before slave drops ack
    a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(bus_rsp.ack) |-> $past(!bus_req.req));

endmodule

/* design/seg_scanner.sv */
// seg_scanner
// multiplexes the four seven-segment digits: a clock enable prescaler
// advances the digit index every 2^SCAN_DIV_W clocks, the selected
// register is decoded as a glyph code or driven raw
// segments, decimal point and anodes are all active low
`timescale 1ns/1ps

`include "board_io_macros.svh"

module seg_scanner import board_io_pkg::*; #(
    parameter int SCAN_DIV_W = `SCAN_DIV_W_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  digit_regs_t digits,
    output logic [6:0]  seg,     // gfedcba, active low
    output logic        dp,      // active low
    output logic [3:0]  an       // active low, an[3] is leftmost
);

    logic [SCAN_DIV_W-1:0] div_cnt;
    logic                  scan_en;    // one cycle per scan step
    logic [1:0]            idx;
    logic [7:0]            cur;        // register of the lit digit
    glyph_e                glyph;
    logic [6:0]            pat;

    assign scan_en = &div_cnt;   // terminal count

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            idx     <= 2'd0;
        end else begin
            div_cnt <= div_cnt + 1'b1;   // wraps after terminal count
            if (scan_en)
                idx <= idx + 2'd1;       // 0,1,2,3,0...
        end
    end

    assign cur   = digits.digit[idx];
    assign glyph = glyph_e'(cur[4:0]);

    // glyph table, codes above 0x12 fall to blank
    always_comb begin
        case (glyph)
            GLYPH_0:     pat = 7'b1000000;
            GLYPH_1:     pat = 7'b1111001;
            GLYPH_2:     pat = 7'b0100100;
            GLYPH_3:     pat = 7'b0110000;
            GLYPH_4:     pat = 7'b0011001;
            GLYPH_5:     pat = 7'b0010010;
            GLYPH_6:     pat = 7'b0000010;
            GLYPH_7:     pat = 7'b1111000;
            GLYPH_8:     pat = 7'b0000000;
            GLYPH_9:     pat = 7'b0011000;
            GLYPH_A:     pat = 7'b0001000;
            GLYPH_B:     pat = 7'b0000011;   // lower case b
            GLYPH_C:     pat = 7'b1000110;
            GLYPH_D:     pat = 7'b0100001;   // lower case d
            GLYPH_E:     pat = 7'b0000110;
            GLYPH_F:     pat = 7'b0001110;
            GLYPH_DASH:  pat = 7'b0111111;   // g only
            GLYPH_J:     pat = 7'b1100001;
            GLYPH_BLANK: pat = 7'b1111111;
            default:     pat = 7'b1111111;
        endcase
    end

    assign seg = digits.raw_mode ? ~cur[6:0] : pat;
    assign dp  = ~cur[7];   // same in both modes

    // index 0 is the leftmost digit
    always_comb begin
        case (idx)
            2'd0:    an = 4'b0111;
            2'd1:    an = 4'b1011;
            2'd2:    an = 4'b1101;
            default: an = 4'b1110;
        endcase
    end

    // exactly one digit lit, never two fighting the shared segment lines
    a_an_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~an));

endmodule

/* design/board_io_top.sv */
// board_io_top
// on-board I/O peripheral: switch/button synchronizer, bus register
// block and seven-segment scanner behind one four-phase bus port
`timescale 1ns/1ps

`include "board_io_macros.svh"

module board_io_top import board_io_pkg::*; #(
    parameter int SCAN_DIV_W = `SCAN_DIV_W_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  io_bus_req_t bus_req,
    output io_bus_rsp_t bus_rsp,
    input  logic [15:0] sw,
    input  logic [4:0]  btn,
    output logic [15:0] led,
    output logic [6:0]  seg,
    output logic        dp,
    output logic [3:0]  an
);

    logic [15:0] sw_sync;
    logic [4:0]  btn_sync;
    digit_regs_t digits;   // register block to scanner

    input_sync i_input_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .sw       (sw),
        .btn      (btn),
        .sw_sync  (sw_sync),
        .btn_sync (btn_sync)
    );

    io_regs i_io_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .sw_sync  (sw_sync),
        .btn_sync (btn_sync),
        .led      (led),
        .digits   (digits)
    );

    seg_scanner #(
        .SCAN_DIV_W (SCAN_DIV_W)
    ) i_seg_scanner (
        .clk    (clk),
        .rst_n  (rst_n),
        .digits (digits),
        .seg    (seg),
        .dp     (dp),
        .an     (an)
    );

endmodule

/* tb/tb_clock_gen.sv */
// tb_clock_gen
// free running testbench clock and power-on reset
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);   // ten cycles in reset
        @(negedge clk);
        rst_n = 1'b1;                 // released away from the active edge
    end

endmodule

/* tb/board_io_checker.sv */
// board_io_checker
// watches the DUT pins, mirrors the led, digit and mode registers from
// the writes it sees and compares handshake order, read data, anode
// rotation and display output, then reports per test and in total
`timescale 1ns/1ps

`include "board_io_macros.svh"

module board_io_checker import board_io_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  io_bus_req_t bus_req,
    input  io_bus_rsp_t bus_rsp,
    input  logic [15:0] led,
    input  logic [7:0]  disp,       // {dp, seg}
    input  logic [3:0]  an,
    input  logic [15:0] exp_data,   // expected read data or {dp, seg}
    input  logic        observe,    // compare display this cycle
    input  logic [3:0]  test_id,    // 4'hf closes the run
    output int          errors
);

    io_bus_req_t req_q;      // request of the access in flight
    logic        req_q1;     // req one sample back
    logic        ack_q;
    logic [3:0]  an_q;
    logic [15:0] led_m;      // led register model
    digit_regs_t dig_m;      // digit and mode model
    logic [7:0]  lit;        // model value of the lit digit
    logic [3:0]  test_q = '0;
    int          n_all = 0;
    int          n_test = 0;
    int          e_test = 0;

    initial errors = 0;

    task automatic check(input logic ok, input string msg);
        n_all++;
        n_test++;
        if (!ok) begin
            errors++;
            e_test++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            req_q1 = 1'b0;
            ack_q  = 1'b0;
            an_q   = 4'b0111;                  // leftmost digit first
            led_m  = '0;
            dig_m  = {1'b0, {4{8'h10}}};       // blank, pattern mode
        end else begin
            // ack may only follow req, up on req high, down on req low
            if (bus_rsp.ack != ack_q)
                check(bus_rsp.ack == req_q1, "ack moved against the four-phase order");
            if (bus_rsp.ack && !ack_q && !req_q.we)
                check(bus_rsp.rdata == exp_data, $sformatf("read %h gave %h, expected %h",
                    req_q.addr, bus_rsp.rdata, exp_data));
            if (bus_rsp.ack && !ack_q && req_q.we && req_q.addr[15:8] == `IO_PAGE) begin
                if (req_q.addr[7:0] == `REG_LED)
                    led_m = req_q.wdata;
                if ((req_q.addr[7:0] & 8'hfc) == `REG_DIGIT_BASE)
                    dig_m.digit[req_q.addr[1:0]] = req_q.wdata[7:0];
                if (req_q.addr[7:0] == `REG_DISP_CTRL)
                    dig_m.raw_mode = |req_q.wdata;   // any nonzero value
            end
            for (int d = 0; d < 4; d++)
                if (an == ~(4'b1000 >> d))
                    lit = dig_m.digit[d];
            check(an == an_q || an == {an_q[0], an_q[3:1]},
                $sformatf("anodes jumped from %b to %b", an_q, an));
            check(led == led_m, $sformatf("led %h, expected %h", led, led_m));
            check(disp[7] == !lit[7], $sformatf("dp %b for digit value %h", disp[7], lit));
            if (dig_m.raw_mode)
                check(disp[6:0] == ~lit[6:0], $sformatf("raw seg %b for %h", disp[6:0], lit));
            if (observe)
                check(disp == exp_data[7:0], $sformatf("an %b shows %b, expected %b",
                    an, disp, exp_data[7:0]));
            if (bus_req.req)
                req_q = bus_req;   // held for the model update on ack
            req_q1 = bus_req.req;
            ack_q  = bus_rsp.ack;
            an_q   = an;
        end
        if (test_id != test_q) begin
            if (test_q != 0)
                $display("test %0d: %0d checks, %0d errors", test_q, n_test, e_test);
            if (test_id == 4'hf)
                $display("summary: %0d checks, %0d errors", n_all, errors);
            n_test = 0;
            e_test = 0;
            test_q = test_id;
        end
    end

endmodule

/* tb/board_io_tb.sv */
// board_io_tb
// testbench top for the on-board I/O peripheral
// applies a table of bus reads and writes, input changes and display
// observations in order
`timescale 1ns/1ps

`include "board_io_macros.svh"

module board_io_tb import board_io_pkg::*; ();

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_READ_SW, OP_INPUTS, OP_SHOW, OP_OBSERVE
    } op_e;

    typedef struct packed {
        logic [3:0]  test;
        op_e         op;
        logic [15:0] addr;   // bus address or digit index
        logic [15:0] data;   // write data or button value
        logic [15:0] exp;    // read data or {dp, seg}
    } step_t;

    localparam logic [15:0] A_SW   = {`IO_PAGE, `REG_SW};
    localparam logic [15:0] A_BTN  = {`IO_PAGE, `REG_BTN};
    localparam logic [15:0] A_LED  = {`IO_PAGE, `REG_LED};
    localparam logic [15:0] A_DIG  = {`IO_PAGE, `REG_DIGIT_BASE};
    localparam logic [15:0] A_MODE = {`IO_PAGE, `REG_DISP_CTRL};

    // seven-segment font gfedcba active low from J down to 0
    localparam logic [18:0][6:0] FONT = {
        7'h61, 7'h3f, 7'h7f, 7'h0e, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08, 7'h18,
        7'h00, 7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40
    };

    logic        clk;
    logic        rst_n;
    io_bus_req_t bus_req;
    io_bus_rsp_t bus_rsp;
    logic [15:0] sw;
    logic [4:0]  btn;
    logic [15:0] led;
    logic [6:0]  seg;
    logic        dp;
    logic [3:0]  an;
    logic [15:0] exp_data;
    logic        observe;
    logic [3:0]  test_id;
    logic [31:0] lfsr;
    logic        timed_out;
    int          errors;
    step_t       steps[$];

    tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    board_io_top #(.SCAN_DIV_W(3)) i_dut (.*);   // scan step every 8 clocks

    board_io_checker i_chk (.*, .disp({dp, seg}));

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois form
    endfunction

    task automatic add_step(input logic [3:0] t, input op_e op, input logic [15:0] a,
                            input logic [15:0] d, input logic [15:0] e);
        steps.push_back({t, op, a, d, e});
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (bus_rsp.ack !== level && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (bus_rsp.ack !== level) begin
            $display("timeout: ack did not go to %b", level);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_anode(input int d);
        int n;
        n = 0;
        while (an !== ~(4'b1000 >> d) && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (an !== ~(4'b1000 >> d)) begin
            $display("timeout: digit %0d was never lit", d);
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_access(input logic we, input logic [15:0] addr, input logic [15:0] wdata);
        bus_req = {1'b1, we, addr, wdata};
        wait_ack(1'b1);
        bus_req.req = 1'b0;   // phase 3 then wait for ack low
        wait_ack(1'b0);
    endtask

    task automatic observe_digit(input int d, input logic [15:0] exp);
        exp_data = exp;
        wait_anode(d);
        observe = 1'b1;   // checker compares on the next rising edge
        @(negedge clk);
        observe = 1'b0;
    endtask

    task automatic apply(input step_t s);
        logic [15:0] val;
        test_id  = s.test;
        exp_data = s.exp;
        case (s.op)
            OP_WRITE:   bus_access(1'b1, s.addr, s.data);
            OP_READ:    bus_access(1'b0, s.addr, '0);
            OP_READ_SW: begin
                exp_data = sw;   // last lfsr value driven
                bus_access(1'b0, s.addr, '0);
            end
            OP_INPUTS: begin
                for (int b = 0; b < 16; b++) begin
                    val  = {val[14:0], lfsr[0]};
                    lfsr = lfsr_step(lfsr);
                end
                sw  = val;
                btn = s.data[4:0];
                repeat (3) @(negedge clk);   // two sync stages plus one
            end
            OP_SHOW: begin
                bus_access(1'b1, s.addr, s.data);
                observe_digit(s.addr[1:0], s.exp);
            end
            default:    observe_digit(s.addr[1:0], s.exp);
        endcase
    endtask

    task automatic build_table();
        logic       dot;
        logic [6:0] pat;
        // reset values with blank digits in scan order
        add_step(1, OP_READ, A_LED, 0, 16'h0000);
        for (int d = 0; d < 4; d++)
            add_step(1, OP_OBSERVE, d, 0, 16'h00ff);
        // synchronized switches and buttons
        add_step(2, OP_INPUTS, 0, 16'h0015, 0);
        add_step(2, OP_READ_SW, A_SW, 0, 0);
        add_step(2, OP_READ, A_BTN, 0, 16'h0015);
        add_step(2, OP_INPUTS, 0, 16'h000a, 0);
        add_step(2, OP_READ_SW, A_SW, 0, 0);
        add_step(2, OP_READ, A_BTN, 0, 16'h000a);
        add_step(3, OP_WRITE, A_LED, 16'ha5c3, 0);
        add_step(3, OP_READ, A_LED, 0, 16'ha5c3);
        add_step(3, OP_WRITE, A_LED, 16'h0012, 0);
        add_step(3, OP_READ, A_LED, 0, 16'h0012);
        // all glyph codes plus 0x13 and 0x14 with dp on every third
        for (int c = 0; c < 21; c++) begin
            dot = (c % 3 == 0);
            pat = (c < 19) ? FONT[c] : 7'h7f;
            add_step(4, OP_SHOW, A_DIG + c % 4, {8'h00, dot, c[6:0]}, {8'h00, !dot, pat});
        end
        add_step(5, OP_WRITE, A_MODE, 16'h0100, 0);
        add_step(5, OP_SHOW, A_DIG, 16'h005a, 16'h00a5);
        add_step(5, OP_SHOW, A_DIG + 3, 16'h0081, 16'h007e);
        add_step(5, OP_WRITE, A_MODE, 16'h0000, 0);
        add_step(5, OP_OBSERVE, 3, 0, 16'h0079);   // 0x81 as glyph 1 with dp
        // unmapped offsets and foreign pages
        add_step(6, OP_READ, {`IO_PAGE, 8'h04}, 0, 0);
        add_step(6, OP_READ, A_MODE, 0, 0);
        add_step(6, OP_READ, 16'h2010, 0, 0);
        add_step(6, OP_WRITE, 16'h2010, 16'hdead, 0);
        add_step(6, OP_WRITE, 16'h2020, 16'h0008, 0);
        add_step(6, OP_WRITE, {`IO_PAGE, 8'h30}, 16'h0008, 0);
        add_step(6, OP_READ, A_LED, 0, 16'h0012);
        add_step(6, OP_OBSERVE, 0, 0, 16'h00ff);
    endtask

    initial begin
        bus_req   = '0;
        sw        = '0;
        btn       = '0;
        exp_data  = '0;
        observe   = 1'b0;
        test_id   = '0;
        lfsr      = 32'h8bf1a609;
        timed_out = 1'b0;
        build_table();
        for (int n = 0; n < 20 && rst_n !== 1'b1; n++)
            @(negedge clk);
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
        for (int i = 0; i < steps.size() && !timed_out; i++)
            apply(steps[i]);
        test_id = 4'hf;   // checker prints the summary
        repeat (2) @(negedge clk);
        if (timed_out || errors != 0)
            $display("TESTBENCH FAILED");
        else
            $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/board_io_pkg.sv
design/input_sync.sv
design/io_regs.sv
design/seg_scanner.sv
design/board_io_top.sv
tb/tb_clock_gen.sv
tb/board_io_checker.sv
tb/board_io_tb.sv

/* Bender.yml */
package:
  name: board_io

export_include_dirs:
  - design

sources:
  - design/board_io_pkg.sv
  - design/input_sync.sv
  - design/io_regs.sv
  - design/seg_scanner.sv
  - design/board_io_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/board_io_checker.sv
      - tb/board_io_tb.sv
